// ==== Bender.yml ====
package:
  name: ising_core

sources:
  - common/ising_pkg.sv
  - src/coupled_cell.sv
  - src/coupled_col.sv
  - src/weight_addr_decode.sv
  - src/spin_delay_line.sv
  - src/spin_update.sv
  - src/core_matrix.sv
  - target: test
    files:
      - testbench/tb_ising_model.sv
      - testbench/tb_core_matrix.sv

// ==== common/ising_pkg.sv ====
// Ising array package with bus widths, the weight address tag, the write struct and FSM states.

package ising_pkg;

    // bits 31:24 of a bus address must carry this value to reach the weights.
    localparam logic [7:0] WEIGHT_ADDR_TAG = 8'hA5;

    // bus side vectors.
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;

    // unsigned weight code as it sits in a cell.
    typedef logic [7:0] weight_code_t;

    // signed sum of weighted spins seen by one destination spin.
    typedef logic signed [15:0] field_t;

    // spin index as carried in the address fields.
    typedef logic [10:0] index_t;

    // one weight write, tag check already applied to en.
    typedef struct packed {
        logic         en;
        index_t       src;  // address bits 12:2.
        index_t       dst;  // address bits 23:13.
        weight_code_t code;
    } coupling_wr_t;

    // spin update control.
    typedef enum logic {
        HOLD,
        RUN
    } run_state_t;

endpackage

// ==== src.f ====
common/ising_pkg.sv
src/coupled_cell.sv
src/coupled_col.sv
src/weight_addr_decode.sv
src/spin_delay_line.sv
src/spin_update.sv
src/core_matrix.sv
testbench/tb_ising_model.sv
testbench/tb_core_matrix.sv

// ==== src/core_matrix.sv ====
// Ising core top level with the weight decoder, coupling columns, spin register and delay line.

`timescale 1ns/100ps

module core_matrix #(
    parameter int N           = 8,
    parameter int NUM_WEIGHTS = 5,
    parameter int WIRE_DELAY  = 20
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              ising_rstn,
    output logic [N-1:0]      outputs_ver,
    output logic [N-1:0]      outputs_hor,
    input  logic              wready,
    input  ising_pkg::addr_t  wr_addr,
    input  ising_pkg::data_t  wdata,
    input  ising_pkg::addr_t  rd_addr,
    output ising_pkg::data_t  rdata
);

    ising_pkg::coupling_wr_t                wr;
    ising_pkg::weight_code_t [N-1:0][N-1:0] all_codes;
    ising_pkg::field_t [N-1:0]              fields;
    logic                                   clear;

    weight_addr_decode #(
        .N (N)
    ) i_decode (
        .clk       (clk),
        .arst_n    (arst_n),
        .wready    (wready),
        .wr_addr   (wr_addr),
        .wdata     (wdata),
        .rd_addr   (rd_addr),
        .all_codes (all_codes),
        .wr        (wr),
        .rdata     (rdata)
    );

    // column k sums the delayed spins into the field of spin k.
    for (genvar k = 0; k < N; k++) begin : g_col
        coupled_col #(
            .N           (N),
            .K           (k),
            .NUM_WEIGHTS (NUM_WEIGHTS)
        ) i_col (
            .clk    (clk),
            .arst_n (arst_n),
            .wr     (wr),
            .spins  (outputs_ver),
            .field  (fields[k]),
            .codes  (all_codes[k])
        );
    end

    spin_update #(
        .N (N)
    ) i_update (
        .clk        (clk),
        .arst_n     (arst_n),
        .ising_rstn (ising_rstn),
        .fields     (fields),
        .spins      (outputs_hor),
        .clear      (clear)
    );

    spin_delay_line #(
        .N          (N),
        .WIRE_DELAY (WIRE_DELAY)
    ) i_delay (
        .clk       (clk),
        .arst_n    (arst_n),
        .clear     (clear),
        .spins_in  (outputs_hor),
        .spins_out (outputs_ver)
    );

endmodule

// ==== src/coupled_cell.sv ====
// Coupling cell with one clipped weight register and its signed field contribution.

`timescale 1ns/100ps

module coupled_cell #(
    parameter int NUM_WEIGHTS = 5
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     wr_en,
    input  ising_pkg::weight_code_t  wr_code,
    input  logic                     spin,
    input  ising_pkg::field_t        field_in,
    output ising_pkg::field_t        field_out,
    output ising_pkg::weight_code_t  code
);

    localparam ising_pkg::weight_code_t MAX_CODE = ising_pkg::weight_code_t'(NUM_WEIGHTS - 1);
    localparam ising_pkg::weight_code_t MID_CODE =
        ising_pkg::weight_code_t'((NUM_WEIGHTS - 1) / 2);

    ising_pkg::weight_code_t code_q;
    ising_pkg::weight_code_t code_clipped;
    ising_pkg::field_t       weight;

    assign code_clipped = (wr_code > MAX_CODE) ? MAX_CODE : wr_code;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            code_q <= MID_CODE;  // midpoint code is a zero weight.
        end else if (wr_en) begin
            code_q <= code_clipped;
        end
    end

    // code minus midpoint, so the code range is centred on zero.
    assign weight = ising_pkg::field_t'({8'd0, code_q})
                  - ising_pkg::field_t'({8'd0, MID_CODE});

    // a high spin counts as +1, a low spin as -1.
    assign field_out = spin ? (field_in + weight) : (field_in - weight);

    assign code = code_q;

    a_code_in_range: assert property (
        @(posedge clk) disable iff (!arst_n)
        code_q <= MAX_CODE
    ) else $error("weight code %0d above %0d", code_q, MAX_CODE);

endmodule

// ==== src/coupled_col.sv ====
// Coupling column of N cells that forms the local field of one destination spin.

`timescale 1ns/100ps

module coupled_col #(
    parameter int N           = 8,
    parameter int K           = 0,
    parameter int NUM_WEIGHTS = 5
) (
    input  logic                                clk,
    input  logic                                arst_n,
    input  ising_pkg::coupling_wr_t             wr,
    input  logic [N-1:0]                        spins,
    output ising_pkg::field_t                   field,
    output ising_pkg::weight_code_t [N-1:0]     codes
);

    localparam int IDX_W = (N > 1) ? $clog2(N) : 1;

    logic                          col_sel;
    logic [N-1:0]                  cell_wr;
    ising_pkg::field_t [N:0]       partial;

    // only the low index bits take part in the match.
    assign col_sel = wr.en && (wr.dst[IDX_W-1:0] == IDX_W'(K));

    assign partial[0] = '0;

    for (genvar j = 0; j < N; j++) begin : g_cell
        assign cell_wr[j] = col_sel && (wr.src[IDX_W-1:0] == IDX_W'(j));

        coupled_cell #(
            .NUM_WEIGHTS (NUM_WEIGHTS)
        ) i_cell (
            .clk       (clk),
            .arst_n    (arst_n),
            .wr_en     (cell_wr[j]),
            .wr_code   (wr.code),
            .spin      (spins[j]),
            .field_in  (partial[j]),
            .field_out (partial[j+1]),
            .code      (codes[j])
        );
    end

    assign field = partial[N];  // sum over every source spin.

endmodule

// ==== src/spin_delay_line.sv ====
// Spin feedback delay line of WIRE_DELAY register stages with synchronous clear.

`timescale 1ns/100ps

module spin_delay_line #(
    parameter int N          = 8,
    parameter int WIRE_DELAY = 20
) (
    input  logic         clk,
    input  logic         arst_n,
    input  logic         clear,
    input  logic [N-1:0] spins_in,
    output logic [N-1:0] spins_out
);

    logic [WIRE_DELAY-1:0][N-1:0] stage_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stage_q <= '0;
        end else if (clear) begin
            stage_q <= '0;
        end else begin
            stage_q[0] <= spins_in;
            for (int i = 1; i < WIRE_DELAY; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign spins_out = stage_q[WIRE_DELAY-1];  // spins from WIRE_DELAY cycles ago.

endmodule

// ==== src/spin_update.sv ====
// Spin register with HOLD/RUN control and the sign update from the local fields.

`timescale 1ns/100ps

module spin_update #(
    parameter int N = 8
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          ising_rstn,
    input  ising_pkg::field_t [N-1:0]     fields,
    output logic [N-1:0]                  spins,
    output logic                          clear
);

    localparam int FIELD_MSB = $bits(ising_pkg::field_t) - 1;

    ising_pkg::run_state_t state_q;
    logic [N-1:0]          spins_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= ising_pkg::HOLD;
        end else begin
            state_q <= ising_rstn ? ising_pkg::RUN : ising_pkg::HOLD;
        end
    end

    // a low run enable clears on the same edge, not one state later.
    assign clear = (state_q == ising_pkg::HOLD) || !ising_rstn;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            spins_q <= '0;
        end else if (clear) begin
            spins_q <= '0;
        end else begin
            for (int k = 0; k < N; k++) begin
                if (fields[k] != '0) begin
                    spins_q[k] <= ~fields[k][FIELD_MSB];  // a zero field keeps the spin.
                end
            end
        end
    end

    assign spins = spins_q;

    a_fields_known: assert property (
        @(posedge clk) disable iff (!arst_n)
        (state_q == ising_pkg::RUN) |-> !$isunknown(fields)
    ) else $error("unknown bits on local fields while running");

endmodule

// ==== src/weight_addr_decode.sv ====
// Weight bus decoder with tag check, write struct generation and registered read mux.

`timescale 1ns/100ps

module weight_addr_decode #(
    parameter int N = 8
) (
    input  logic                                   clk,
    input  logic                                   arst_n,
    input  logic                                   wready,
    input  ising_pkg::addr_t                       wr_addr,
    input  ising_pkg::data_t                       wdata,
    input  ising_pkg::addr_t                       rd_addr,
    input  ising_pkg::weight_code_t [N-1:0][N-1:0] all_codes,
    output ising_pkg::coupling_wr_t                wr,
    output ising_pkg::data_t                       rdata
);

    localparam int IDX_W = (N > 1) ? $clog2(N) : 1;

    logic                    rd_hit;
    ising_pkg::index_t       rd_src;
    ising_pkg::index_t       rd_dst;
    ising_pkg::weight_code_t rd_code;
    ising_pkg::data_t        rdata_q;

    assign wr.en   = wready && (wr_addr[31:24] == ising_pkg::WEIGHT_ADDR_TAG);
    assign wr.src  = wr_addr[12:2];
    assign wr.dst  = wr_addr[23:13];
    assign wr.code = wdata[7:0];

    // read side is decoded on its own, so a read and a write may share a cycle.
    assign rd_hit  = (rd_addr[31:24] == ising_pkg::WEIGHT_ADDR_TAG);
    assign rd_src  = rd_addr[12:2];
    assign rd_dst  = rd_addr[23:13];
    assign rd_code = all_codes[rd_dst[IDX_W-1:0]][rd_src[IDX_W-1:0]];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rdata_q <= '0;
        end else begin
            rdata_q <= rd_hit ? {24'd0, rd_code} : '0;  // codes sampled before a same-cycle write.
        end
    end

    assign rdata = rdata_q;

    a_wr_needs_strobe: assert property (
        @(posedge clk) disable iff (!arst_n)
        wr.en |-> wready
    ) else $error("weight write without wready");

endmodule

// ==== testbench/tb_core_matrix.sv ====
// Testbench for the Ising core with clock, reset, random stimulus, model checks and watchdog.

`timescale 1ns/100ps

module tb_core_matrix;

    localparam int N           = 8;
    localparam int NUM_WEIGHTS = 5;
    localparam int WIRE_DELAY  = 4;
    localparam int CLK_PERIOD  = 20;
    localparam int MID         = (NUM_WEIGHTS - 1) / 2;

    localparam int T1_CYCLES    = 4 + N * N + 2;
    localparam int T2_CYCLES    = 40 + N * N + 1;
    localparam int T3_CYCLES    = N * N + 200;
    localparam int T5_CYCLES    = 10 + 3 + 60;
    localparam int T6_CYCLES    = 100;
    localparam int TOTAL_CYCLES = T1_CYCLES + T2_CYCLES + T3_CYCLES + T5_CYCLES + T6_CYCLES;

    logic             clk;
    logic             arst_n;
    logic             ising_rstn;
    logic             wready;
    ising_pkg::addr_t wr_addr;
    ising_pkg::data_t wdata;
    ising_pkg::addr_t rd_addr;
    logic [N-1:0]     outputs_ver;
    logic [N-1:0]     outputs_hor;
    ising_pkg::data_t rdata;
    logic [N-1:0]     exp_hor;
    logic [N-1:0]     exp_ver;
    ising_pkg::data_t exp_rdata;

    int           seed;
    int           n_pass;
    int           n_fail;
    int           test_errs [1:6];
    logic [N-1:0] hor_hist [$];

    core_matrix #(
        .N           (N),
        .NUM_WEIGHTS (NUM_WEIGHTS),
        .WIRE_DELAY  (WIRE_DELAY)
    ) i_dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .ising_rstn  (ising_rstn),
        .outputs_ver (outputs_ver),
        .outputs_hor (outputs_hor),
        .wready      (wready),
        .wr_addr     (wr_addr),
        .wdata       (wdata),
        .rd_addr     (rd_addr),
        .rdata       (rdata)
    );

    tb_ising_model #(
        .N           (N),
        .NUM_WEIGHTS (NUM_WEIGHTS),
        .WIRE_DELAY  (WIRE_DELAY)
    ) i_model (
        .clk        (clk),
        .arst_n     (arst_n),
        .ising_rstn (ising_rstn),
        .wready     (wready),
        .wr_addr    (wr_addr),
        .wdata      (wdata),
        .rd_addr    (rd_addr),
        .exp_hor    (exp_hor),
        .exp_ver    (exp_ver),
        .exp_rdata  (exp_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic int rand_below(input int n);
        return {$random(seed)} % n;
    endfunction

    function automatic ising_pkg::addr_t make_addr(input logic [7:0] tag, input int dst,
                                                   input int src);
        return {tag, ising_pkg::index_t'(dst), ising_pkg::index_t'(src), 2'b00};
    endfunction

    function automatic ising_pkg::addr_t random_addr(input logic hit);
        logic [7:0] tag;
        tag = ising_pkg::WEIGHT_ADDR_TAG;
        if (!hit) begin
            tag = tag ^ 8'(1 + rand_below(255));  // any nonzero flip misses the tag.
        end
        return make_addr(tag, rand_below(2048), rand_below(2048));
    endfunction

    function automatic ising_pkg::data_t random_data(input int max_code);
        ising_pkg::data_t d;
        d      = $random(seed);
        d[7:0] = 8'(rand_below(max_code + 1));
        return d;
    endfunction

    task automatic check_value(input int test_id, input string name,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) begin
            n_pass++;
        end else begin
            $display("FAIL at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
            n_fail++;
            test_errs[test_id]++;
        end
    endtask

    task automatic compare_outputs(input int test_id);
        check_value(test_id, "outputs_hor", exp_hor, outputs_hor);
        check_value(test_id, "outputs_ver", exp_ver, outputs_ver);
        check_value(test_id, "rdata", exp_rdata, rdata);
    endtask

    task automatic drive_cycle(input int test_id, input logic run, input logic wr_en,
                               input ising_pkg::addr_t wa, input ising_pkg::data_t wd,
                               input ising_pkg::addr_t ra);
        @(posedge clk);
        ising_rstn <= run;
        wready     <= wr_en;
        wr_addr    <= wa;
        wdata      <= wd;
        rd_addr    <= ra;
        @(negedge clk);
        compare_outputs(test_id);
    endtask

    task automatic report_test(input int test_id, input string name);
        if (test_errs[test_id] == 0) begin
            $display("test %0d %s: ok", test_id, name);
        end else begin
            $display("test %0d %s: %0d errors", test_id, name, test_errs[test_id]);
        end
    endtask

    initial begin
        ising_pkg::addr_t wa;
        ising_pkg::addr_t ra;
        seed       = 32'hc4b4_40fc;
        n_pass     = 0;
        n_fail     = 0;
        arst_n     = 1'b0;
        ising_rstn = 1'b0;
        wready     = 1'b0;
        wr_addr    = '0;
        wdata      = '0;
        rd_addr    = '0;
        for (int t = 1; t <= 6; t++) begin
            test_errs[t] = 0;
        end
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);

        check_value(1, "rdata", 0, rdata);
        check_value(1, "outputs_hor", 0, outputs_hor);
        check_value(1, "outputs_ver", 0, outputs_ver);
        for (int i = 0; i <= N * N; i++) begin
            ra = (i < N * N) ? make_addr(ising_pkg::WEIGHT_ADDR_TAG, i / N, i % N) : '0;
            drive_cycle(1, 1'b0, 1'b0, '0, '0, ra);
            if (i > 0) begin
                check_value(1, "rdata", MID, rdata);  // previous read lands now.
            end
        end
        report_test(1, "reset state");

        for (int i = 0; i < 40; i++) begin
            wa = random_addr(rand_below(4) != 0);
            ra = (rand_below(4) == 0) ? wa : random_addr(rand_below(4) != 0);
            drive_cycle(2, 1'b0, 1'b1, wa, random_data(11), ra);
        end
        for (int i = 0; i <= N * N; i++) begin
            ra = (i < N * N) ? make_addr(ising_pkg::WEIGHT_ADDR_TAG, i / N, i % N) : '0;
            drive_cycle(2, 1'b0, 1'b0, '0, '0, ra);
        end
        report_test(2, "weight write and read-back");

        for (int i = 0; i < N * N; i++) begin
            wa = make_addr(ising_pkg::WEIGHT_ADDR_TAG, i / N, i % N);
            drive_cycle(3, 1'b0, 1'b1, wa, random_data(NUM_WEIGHTS - 1), '0);
        end
        hor_hist.delete();
        for (int i = 0; i < WIRE_DELAY; i++) begin
            hor_hist.push_back('0);  // spins are zero while held.
        end
        for (int c = 0; c < 200; c++) begin
            drive_cycle(3, 1'b1, 1'b0, '0, '0, '0);
            hor_hist.push_back(exp_hor);
            check_value(4, "outputs_ver", hor_hist[hor_hist.size() - 1 - WIRE_DELAY],
                        outputs_ver);
        end
        report_test(3, "free run sign update");
        report_test(4, "feedback delay");

        for (int c = 0; c < 10; c++) begin
            drive_cycle(5, 1'b1, 1'b0, '0, '0, '0);
        end
        drive_cycle(5, 1'b0, 1'b0, '0, '0, '0);
        drive_cycle(5, 1'b0, 1'b0, '0, '0, '0);
        check_value(5, "outputs_hor", 0, outputs_hor);
        check_value(5, "outputs_ver", 0, outputs_ver);
        drive_cycle(5, 1'b0, 1'b0, '0, '0, '0);
        for (int c = 0; c < 60; c++) begin
            drive_cycle(5, 1'b1, 1'b0, '0, '0, '0);
        end
        report_test(5, "run enable drop and restart");

        for (int c = 0; c < 100; c++) begin
            wa = random_addr(1'b1);
            ra = random_addr(rand_below(4) != 0);
            drive_cycle(6, 1'b1, 1'(rand_below(2)), wa, random_data(NUM_WEIGHTS + 2), ra);
        end
        report_test(6, "weight rewrite while running");

        $display("checks passed: %0d, checks failed: %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(2 * TOTAL_CYCLES * CLK_PERIOD);
        $display("timeout: the tests did not finish within %0d cycles", 2 * TOTAL_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== testbench/tb_ising_model.sv ====
// Cycle model of the Ising core with weights, read-back, sign update, delay line and run control.

`timescale 1ns/100ps

module tb_ising_model #(
    parameter int N           = 8,
    parameter int NUM_WEIGHTS = 5,
    parameter int WIRE_DELAY  = 20
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             ising_rstn,
    input  logic             wready,
    input  ising_pkg::addr_t wr_addr,
    input  ising_pkg::data_t wdata,
    input  ising_pkg::addr_t rd_addr,
    output logic [N-1:0]     exp_hor,
    output logic [N-1:0]     exp_ver,
    output ising_pkg::data_t exp_rdata
);

    localparam int MID = (NUM_WEIGHTS - 1) / 2;
    localparam int IW  = $clog2(N);

    int           w [N][N];          // signed weights, indexed by destination then source.
    logic [N-1:0] hist [WIRE_DELAY];  // hist[0] is the newest stage.
    logic         running;

    always @(posedge clk or negedge arst_n) begin
        int           field;
        int           code;
        logic         hold;
        logic [N-1:0] next_spins;
        if (!arst_n) begin
            for (int k = 0; k < N; k++) begin
                for (int j = 0; j < N; j++) begin
                    w[k][j] = 0;
                end
            end
            for (int i = 0; i < WIRE_DELAY; i++) begin
                hist[i] = '0;
            end
            exp_hor   = '0;
            exp_rdata = '0;
            running   = 1'b0;
        end else begin
            hold       = !running || !ising_rstn;
            next_spins = exp_hor;
            for (int k = 0; k < N; k++) begin
                field = 0;
                for (int j = 0; j < N; j++) begin
                    field += hist[WIRE_DELAY-1][j] ? w[k][j] : -w[k][j];
                end
                if (field > 0) begin
                    next_spins[k] = 1'b1;
                end else if (field < 0) begin
                    next_spins[k] = 1'b0;
                end
            end
            // read-back sees the weights from before this edge's write.
            if (rd_addr[31:24] == ising_pkg::WEIGHT_ADDR_TAG) begin
                exp_rdata = ising_pkg::data_t'(w[rd_addr[13 +: IW]][rd_addr[2 +: IW]] + MID);
            end else begin
                exp_rdata = '0;
            end
            if (hold) begin
                for (int i = 0; i < WIRE_DELAY; i++) begin
                    hist[i] = '0;
                end
                exp_hor = '0;
            end else begin
                for (int i = WIRE_DELAY - 1; i > 0; i--) begin
                    hist[i] = hist[i-1];
                end
                hist[0] = exp_hor;
                exp_hor = next_spins;
            end
            if (wready && (wr_addr[31:24] == ising_pkg::WEIGHT_ADDR_TAG)) begin
                code = wdata[7:0];
                if (code > NUM_WEIGHTS - 1) begin
                    code = NUM_WEIGHTS - 1;
                end
                w[wr_addr[13 +: IW]][wr_addr[2 +: IW]] = code - MID;
            end
            running = ising_rstn;
        end
    end

    assign exp_ver = hist[WIRE_DELAY-1];

endmodule
